//--- vlog.f
+incdir+common
common/fp_pkg.sv
fp_hub/fp_ext.sv
fp_hub/fp_cmp.sv
fp_hub/fp_cvt_f2i.sv
fp_hub/fp_hub.sv
verilog/fp_req_port.sv
verilog/fp_unit_top.sv
verification/fp_unit_assert.sv
verification/fp_unit_checker.sv
verification/fp_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fp_unit_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/fp_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// FP unit testbench. Clock, reset, stimulus,
// four-phase driver, timeout and summary.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module fp_unit_tb;

    import fp_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_SPECIAL    = 12;
    localparam int N_RANDOM     = 20;
    localparam int PAIR_REQS    = N_SPECIAL * N_SPECIAL + N_RANDOM;
    localparam int REQ_TOTAL    = 8 * PAIR_REQS + 32 + 64 + 10 + 4;
    localparam int CYCLE_LIMIT  = REQ_TOTAL * 40 + RESET_CYCLES;

    // Zeros, infinities, NaNs, subnormals, normals and int32 edges.
    localparam fp_word_t SPECIAL [N_SPECIAL] = '{
        32'h00000000, 32'h80000000, 32'h7f800000, 32'hff800000,
        32'h7fc00000, 32'h7f800001, 32'h00000001, 32'h807fffff,
        32'h3f800000, 32'hbfc00000, 32'h4f000000, 32'hcf000000
    };
    localparam fp_word_t CVT_EDGE [12] = '{
        32'h3fc00000, 32'hc02ccccd, 32'h3f000000, 32'h4effffff,
        32'hceffffff, 32'h4f000000, 32'hcf000001, 32'hcf000000,
        32'h3f7fffff, 32'h4b800001, 32'hbf800000, 32'h7f800001
    };

    logic        clk;
    logic        rst_n;
    logic        req;
    fp_op_e      op;
    fp_word_t    a;
    fp_word_t    b;
    logic        ack;
    fp_word_t    result;
    fp_flags_t   flags;
    logic [31:0] rng;
    int          tb_errors = 0;
    int          cycle_count = 0;
    int          checks;
    int          chk_errors;
    int          last_errors = 0;

    fp_unit_top fp_unit_top_inst (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .req_i    (req),
        .op_i     (op),
        .a_i      (a),
        .b_i      (b),
        .ack_o    (ack),
        .result_o (result),
        .flags_o  (flags)
    );

    fp_unit_checker checker_inst (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .req_i    (req),
        .op_i     (op),
        .a_i      (a),
        .b_i      (b),
        .ack_i    (ack),
        .result_i (result),
        .flags_i  (flags),
        .checks_o (checks),
        .errors_o (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: no finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Exponent kept near the int32 range.
    function automatic fp_word_t near_int_float(input logic [31:0] r);
        logic [7:0] e;
        e = 8'd110 + {3'b000, r[27:23]} + {3'b000, r[28], 4'b0000};
        return {r[31], e, r[22:0]};
    endfunction

    task automatic run_request(input fp_op_e o, input fp_word_t x, input fp_word_t y,
                               input int hold_cycles);
        int        cycles;
        fp_word_t  held_result;
        fp_flags_t held_flags;
        op     = o;
        a      = x;
        b      = y;
        req    = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack);
        if ((o != FCVT_W) && (cycles != 3)) begin
            $display("CHECK FAILED at %0t: ack_o rose %0d edges after req_i, expected 2",
                     $time, cycles - 1);
            tb_errors++;
        end
        held_result = result;
        held_flags  = flags;
        repeat (hold_cycles) begin
            @(negedge clk);
            if (!ack || (result !== held_result) || (flags !== held_flags)) begin
                $display("CHECK FAILED at %0t: result not held while req_i high", $time);
                tb_errors++;
            end
        end
        req = 1'b0;
        a   = ~x; // Bus may change once acked.
        b   = ~y;
        do @(negedge clk); while (ack);
    endtask

    task automatic run_pairs(input fp_op_e o);
        fp_word_t x;
        fp_word_t y;
        for (int i = 0; i < N_SPECIAL; i++) begin
            for (int j = 0; j < N_SPECIAL; j++) begin
                run_request(o, SPECIAL[i], SPECIAL[j], 0);
            end
        end
        repeat (N_RANDOM) begin
            rng = xorshift32(rng);
            x   = rng;
            rng = xorshift32(rng);
            y   = rng;
            run_request(o, x, y, 0);
        end
    endtask

    task automatic report_test(input string name);
        int total;
        total = tb_errors + chk_errors;
        $display("Test %s: %0d errors", name, total - last_errors);
        last_errors = total;
    endtask

    initial begin
        rst_n = 1'b0;
        req   = 1'b0;
        op    = FEQ;
        a     = '0;
        b     = '0;
        rng   = 32'hdd7184a7;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        run_pairs(FEQ);
        run_pairs(FLT);
        run_pairs(FLE);
        report_test("compares");

        run_pairs(FMIN);
        run_pairs(FMAX);
        report_test("min/max");

        run_pairs(FSGNJ);
        run_pairs(FSGNJN);
        run_pairs(FSGNJX);
        for (int i = 0; i < N_SPECIAL; i++) run_request(FCLASS, SPECIAL[i], 32'h0, 0);
        repeat (N_RANDOM) begin
            rng = xorshift32(rng);
            run_request(FCLASS, rng, 32'h0, 0);
        end
        report_test("sign injection and fclass");

        for (int i = 0; i < N_SPECIAL; i++) run_request(FCVT_W, SPECIAL[i], 32'h0, 0);
        for (int i = 0; i < 12; i++) run_request(FCVT_W, CVT_EDGE[i], 32'h0, 0);
        repeat (40) begin
            rng = xorshift32(rng);
            run_request(FCVT_W, near_int_float(rng), 32'h0, 0);
        end
        report_test("fcvt.w.s");

        for (int i = 0; i < 10; i++) begin
            rng = xorshift32(rng);
            run_request((i % 3 == 2) ? FCVT_W : FMAX, near_int_float(rng), SPECIAL[i], 4);
        end
        report_test("handshake");

        op  = FCVT_W;
        a   = 32'h3f800000;
        req = 1'b1;
        repeat (6) @(negedge clk);
        rst_n = 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (ack) begin
                $display("ack_o was high during reset at %0t", $time);
                tb_errors++;
            end
        end
        req = 1'b0;
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (ack) begin
                $display("ack_o rose after reset with no request at %0t", $time);
                tb_errors++;
            end
        end
        run_request(FCVT_W, 32'h3f800000, 32'h0, 0);
        run_request(FEQ, 32'h80000000, 32'h00000000, 0);
        run_request(FCVT_W, 32'hc02ccccd, 32'h0, 0);
        report_test("reset in conversion");

        @(negedge clk);
        $display("Summary: %0d checks, %0d errors", checks, tb_errors + chk_errors);
        if ((tb_errors + chk_errors) == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/fp_unit_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// Reference model and result compare.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "fp_defines.svh"

module fp_unit_checker (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              req_i,
    input  wire fp_pkg::fp_op_e    op_i,
    input  wire fp_pkg::fp_word_t  a_i,
    input  wire fp_pkg::fp_word_t  b_i,
    input  wire logic              ack_i,
    input  wire fp_pkg::fp_word_t  result_i,
    input  wire fp_pkg::fp_flags_t flags_i,
    output int                     checks_o,
    output int                     errors_o
);

    import fp_pkg::*;

    logic        req_q;
    logic        ack_q;
    logic        pending;
    logic [36:0] expected;
    fp_op_e      exp_op;
    fp_word_t    exp_a;
    fp_word_t    exp_b;
    int          check_count = 0;
    int          error_count = 0;

    assign checks_o = check_count;
    assign errors_o = error_count;

    function automatic logic [36:0] reference_result(input fp_op_e op, input fp_word_t a,
                                                     input fp_word_t b);
        logic               a_nan;
        logic               b_nan;
        logic               any_snan;
        logic signed [32:0] key_a;
        logic signed [32:0] key_b;
        logic               lt;
        logic               gt;
        logic               eq;
        fp_word_t           res;
        fp_flags_t          flg;
        int                 e;
        int                 idx;
        logic [23:0]        mag;
        logic [31:0]        ival;
        logic               lost;
        a_nan    = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
        b_nan    = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
        any_snan = (a_nan && !a[22]) || (b_nan && !b[22]);
        // Signed magnitude key, both zeros map to 0.
        key_a = a[31] ? -$signed({2'b00, a[30:0]}) : $signed({2'b00, a[30:0]});
        key_b = b[31] ? -$signed({2'b00, b[30:0]}) : $signed({2'b00, b[30:0]});
        lt    = key_a < key_b;
        gt    = key_a > key_b;
        eq    = key_a == key_b;
        res   = '0;
        flg   = '0;
        case (op)
            FEQ: begin
                res[0] = !(a_nan || b_nan) && eq;
                flg    = any_snan ? FLAG_NV : '0;
            end
            FLT, FLE: begin
                res[0] = !(a_nan || b_nan) && (lt || ((op == FLE) && eq));
                flg    = (a_nan || b_nan) ? FLAG_NV : '0;
            end
            FMIN, FMAX: begin
                if (a_nan && b_nan) res = `FP_CANON_NAN;
                else if (a_nan) res = b;
                else if (b_nan) res = a;
                else if (lt) res = (op == FMIN) ? a : b;
                else if (gt) res = (op == FMIN) ? b : a;
                else res = (a[31] == (op == FMIN)) ? a : b; // Signed zero tie.
                flg = any_snan ? FLAG_NV : '0;
            end
            FSGNJ:  res = {b[31], a[30:0]};
            FSGNJN: res = {~b[31], a[30:0]};
            FSGNJX: res = {a[31] ^ b[31], a[30:0]};
            FCLASS: begin
                if (a_nan) idx = a[22] ? 9 : 8;
                else if (a[30:23] == 8'hff) idx = a[31] ? 0 : 7;
                else if (a[30:23] == 8'h00) begin
                    if (a[22:0] == 23'd0) idx = a[31] ? 3 : 4;
                    else idx = a[31] ? 2 : 5;
                end else idx = a[31] ? 1 : 6;
                res = 32'd1 << idx;
            end
            FCVT_W: begin
                e = int'(a[30:23]) - `FP_EXP_BIAS;
                if (a_nan) begin
                    res = `FP_INT_MAX;
                    flg = FLAG_NV;
                end else if (e >= 31) begin
                    res = a[31] ? `FP_INT_MIN : `FP_INT_MAX;
                    flg = (a == 32'hcf000000) ? '0 : FLAG_NV;
                end else if (a[30:23] == 8'h00) begin
                    flg = (a[22:0] != 23'd0) ? FLAG_NX : '0; // Zero or subnormal.
                end else begin
                    mag = {1'b1, a[22:0]};
                    if (e >= 23) begin
                        ival = 32'(mag) << (e - 23);
                        lost = 1'b0;
                    end else if (e < 0) begin
                        ival = 32'd0;
                        lost = 1'b1;
                    end else begin
                        ival = 32'(mag >> (23 - e));
                        lost = (mag & ((24'd1 << (23 - e)) - 24'd1)) != 24'd0;
                    end
                    res = a[31] ? -ival : ival;
                    flg = lost ? FLAG_NX : '0;
                end
            end
            default: ;
        endcase
        return {flg, res};
    endfunction

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q   <= 1'b0;
            ack_q   <= 1'b0;
            pending <= 1'b0; // Aborted request is dropped.
        end else begin
            req_q <= req_i;
            ack_q <= ack_i;
            if (req_i && !req_q) begin
                if (pending) begin
                    $display("Request started before the previous result was checked");
                    error_count <= error_count + 1;
                end
                expected <= reference_result(op_i, a_i, b_i);
                exp_op   <= op_i;
                exp_a    <= a_i;
                exp_b    <= b_i;
                pending  <= 1'b1;
            end
            if (ack_i && !ack_q) begin
                if (!pending) begin
                    $display("ack_o rose with no request outstanding at %0t", $time);
                    error_count <= error_count + 1;
                end else begin
                    check_count <= check_count + 1;
                    pending     <= 1'b0;
                    if ((result_i !== expected[31:0]) || (flags_i !== expected[36:32])) begin
                        $display("CHECK FAILED at %0t: %s a=%h b=%h got %h/%b expected %h/%b",
                                 $time, exp_op.name(), exp_a, exp_b, result_i, flags_i,
                                 expected[31:0], expected[36:32]);
                        error_count <= error_count + 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/fp_unit_assert.sv
// ~~~~~~~~~~~~~~~~~~~~
// Request port handshake assertions and bind.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module fp_unit_assert (
    input wire logic              clk_i,
    input wire logic              rst_n_i,
    input wire logic              req_i,
    input wire logic              ack_i,
    input wire fp_pkg::fp_word_t  result_i,
    input wire fp_pkg::fp_flags_t flags_i
);

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("ack_o rose without a request");

    result_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ack_i && $past(ack_i)) |-> ($stable(result_i) && $stable(flags_i)))
        else $error("result changed while ack_o was high");

    ack_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(req_i) |-> ##[0:1] !ack_i)
        else $error("ack_o stayed high after req_i fell");

endmodule

bind fp_req_port fp_unit_assert assert_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .ack_i    (ack_o),
    .result_i (result_o),
    .flags_i  (flags_o)
);

`default_nettype wire

//--- verilog/fp_unit_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// FP auxiliary unit top. Request port and hub.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module fp_unit_top (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              req_i,
    input  wire fp_pkg::fp_op_e    op_i,
    input  wire fp_pkg::fp_word_t  a_i,
    input  wire fp_pkg::fp_word_t  b_i,
    output logic                   ack_o,
    output fp_pkg::fp_word_t       result_o,
    output fp_pkg::fp_flags_t      flags_o
);

    import fp_pkg::*;

    logic      start;
    fp_op_e    op;
    fp_word_t  a;
    fp_word_t  b;
    logic      done;
    fp_word_t  hub_result;
    fp_flags_t hub_flags;

    fp_req_port req_port_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .ack_o        (ack_o),
        .result_o     (result_o),
        .flags_o      (flags_o),
        .start_o      (start),
        .op_o         (op),
        .a_o          (a),
        .b_o          (b),
        .done_i       (done),
        .hub_result_i (hub_result),
        .hub_flags_i  (hub_flags)
    );

    fp_hub hub_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (start),
        .op_i     (op),
        .a_i      (a),
        .b_i      (b),
        .done_o   (done),
        .result_o (hub_result),
        .flags_o  (hub_flags)
    );

endmodule

`default_nettype wire

//--- verilog/fp_req_port.sv
// ~~~~~~~~~~~~~~~~~~~~
// Four-phase req/ack front end.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module fp_req_port (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              req_i,
    input  wire fp_pkg::fp_op_e    op_i,
    input  wire fp_pkg::fp_word_t  a_i,
    input  wire fp_pkg::fp_word_t  b_i,
    output logic                   ack_o,
    output fp_pkg::fp_word_t       result_o,
    output fp_pkg::fp_flags_t      flags_o,
    output logic                   start_o,
    output fp_pkg::fp_op_e         op_o,
    output fp_pkg::fp_word_t       a_o,
    output fp_pkg::fp_word_t       b_o,
    input  wire logic              done_i,
    input  wire fp_pkg::fp_word_t  hub_result_i,
    input  wire fp_pkg::fp_flags_t hub_flags_i
);

    import fp_pkg::*;

    port_state_e state_q;
    logic        accept;

    // A new request may also be taken in the cycle after ack drops.
    assign accept = req_i & ((state_q == PORT_IDLE) | (state_q == PORT_RELEASE));
    assign ack_o  = (state_q == PORT_ACK);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= PORT_IDLE;
            start_o <= 1'b0;
        end else begin
            start_o <= accept; // One-cycle pulse.
            case (state_q)
                PORT_IDLE, PORT_RELEASE: state_q <= accept ? PORT_BUSY : PORT_IDLE;
                PORT_BUSY: if (done_i) state_q <= PORT_ACK;
                PORT_ACK: if (!req_i) state_q <= PORT_RELEASE; // Ack falls here.
                default: state_q <= PORT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_o <= op_i;
            a_o  <= a_i;
            b_o  <= b_i;
        end
        if ((state_q == PORT_BUSY) && done_i) begin
            result_o <= hub_result_i; // Held until next request.
            flags_o  <= hub_flags_i;
        end
    end

endmodule

`default_nettype wire

//--- fp_hub/fp_hub.sv
// ~~~~~~~~~~~~~~~~~~~~
// Dispatcher. Sign injection, fclass,
// result and flag select.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module fp_hub (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              start_i,
    input  wire fp_pkg::fp_op_e    op_i,
    input  wire fp_pkg::fp_word_t  a_i,
    input  wire fp_pkg::fp_word_t  b_i,
    output logic                   done_o,
    output fp_pkg::fp_word_t       result_o,
    output fp_pkg::fp_flags_t      flags_o
);

    import fp_pkg::*;

    fp_class_t class_a;
    fp_class_t class_b;
    logic      nan_a;
    logic      nan_b;
    logic      snan_a;
    logic      snan_b;
    fp_word_t  cmp_result;
    fp_flags_t cmp_flags;
    logic      cvt_start;
    logic      cvt_done;
    fp_word_t  cvt_result;
    fp_flags_t cvt_flags;
    fp_word_t  sel_result;
    fp_flags_t sel_flags;
    fp_word_t  result_q;
    fp_flags_t flags_q;
    logic      done_q;

    fp_ext ext_a_inst (.data_i(a_i), .class_o(class_a), .is_nan_o(nan_a), .is_snan_o(snan_a));
    fp_ext ext_b_inst (.data_i(b_i), .class_o(class_b), .is_nan_o(nan_b), .is_snan_o(snan_b));

    fp_cmp cmp_inst (
        .op_i        (op_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .class_a_i   (class_a),
        .class_b_i   (class_b),
        .is_nan_a_i  (nan_a),
        .is_nan_b_i  (nan_b),
        .is_snan_a_i (snan_a),
        .is_snan_b_i (snan_b),
        .result_o    (cmp_result),
        .flags_o     (cmp_flags)
    );

    assign cvt_start = start_i & (op_i == FCVT_W);

    fp_cvt_f2i cvt_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (cvt_start),
        .a_i       (a_i),
        .class_a_i (class_a),
        .done_o    (cvt_done),
        .result_o  (cvt_result),
        .flags_o   (cvt_flags)
    );

    always_comb begin
        sel_result = cmp_result; // Compares and min/max.
        sel_flags  = cmp_flags;  // Zero for all other ops.
        case (op_i)
            FSGNJ:  sel_result = {b_i[31], a_i[30:0]};
            FSGNJN: sel_result = {~b_i[31], a_i[30:0]};
            FSGNJX: sel_result = {a_i[31] ^ b_i[31], a_i[30:0]};
            FCLASS: sel_result = {22'b0, class_a};
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= start_i & (op_i != FCVT_W);
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            result_q <= sel_result;
            flags_q  <= sel_flags;
        end
    end

    // Operation stays latched in the port until done.
    assign done_o   = done_q | cvt_done;
    assign result_o = (op_i == FCVT_W) ? cvt_result : result_q;
    assign flags_o  = (op_i == FCVT_W) ? cvt_flags : flags_q;

endmodule

`default_nettype wire

//--- fp_hub/fp_cvt_f2i.sv
// ~~~~~~~~~~~~~~~~~~~~
// Iterative float to int32, round toward zero.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "fp_defines.svh"

module fp_cvt_f2i (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              start_i,
    input  wire fp_pkg::fp_word_t  a_i,
    input  wire fp_pkg::fp_class_t class_a_i,
    output logic                   done_o,
    output fp_pkg::fp_word_t       result_o,
    output fp_pkg::fp_flags_t      flags_o
);

    import fp_pkg::*;

    cvt_state_e         state_q;
    logic        [5:0]  cnt_q;
    logic        [55:0] sh_q;      // Integer in [55:24], fraction below.
    logic               sign_q;
    logic               sticky_q;
    logic signed [9:0]  exp_unb;
    logic               is_nan;
    logic               ovf;
    logic               neg_edge;
    logic               hidden;
    logic               saturate;
    logic        [5:0]  shift_cnt;
    logic        [31:0] int_mag;

    assign exp_unb   = $signed({2'b00, a_i[30:23]}) - $signed(10'(`FP_EXP_BIAS));
    assign is_nan    = class_a_i[8] | class_a_i[9];
    assign hidden    = class_a_i[1] | class_a_i[6]; // Normal numbers only.
    assign ovf       = exp_unb >= 10'sd31;
    assign neg_edge  = a_i[31] & (a_i[30:0] == 31'h4f000000); // Exactly -2^31.
    assign saturate  = is_nan | ovf;
    assign shift_cnt = (exp_unb < 10'sd0) ? 6'd32 : 6'(10'sd31 - exp_unb);
    assign int_mag   = sh_q[55:24];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= CVT_IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                CVT_IDLE: begin
                    if (start_i && saturate) begin
                        done_o <= 1'b1; // Single-cycle finish.
                    end else if (start_i) begin
                        cnt_q   <= shift_cnt;
                        state_q <= CVT_SHIFT;
                    end
                end
                CVT_SHIFT: begin
                    cnt_q <= cnt_q - 6'd1;
                    if (cnt_q == 6'd1) state_q <= CVT_DONE;
                end
                CVT_DONE: begin
                    done_o  <= 1'b1;
                    state_q <= CVT_IDLE;
                end
                default: state_q <= CVT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            CVT_IDLE: begin
                if (start_i) begin
                    sh_q     <= {hidden, a_i[22:0], 32'b0};
                    sign_q   <= a_i[31];
                    sticky_q <= 1'b0;
                end
                if (is_nan || (ovf && !a_i[31])) begin
                    result_o <= `FP_INT_MAX;
                    flags_o  <= FLAG_NV;
                end else if (neg_edge) begin
                    result_o <= `FP_INT_MIN;
                    flags_o  <= '0;
                end else if (ovf) begin
                    result_o <= `FP_INT_MIN;
                    flags_o  <= FLAG_NV;
                end
            end
            CVT_SHIFT: begin
                sh_q     <= sh_q >> 1;
                sticky_q <= sticky_q | sh_q[0];
            end
            CVT_DONE: begin
                result_o <= sign_q ? -int_mag : int_mag;
                flags_o  <= (sticky_q || (|sh_q[23:0])) ? FLAG_NX : '0;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- fp_hub/fp_cmp.sv
// ~~~~~~~~~~~~~~~~~~~~
// Compares, minimum and maximum.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "fp_defines.svh"

module fp_cmp (
    input  wire fp_pkg::fp_op_e    op_i,
    input  wire fp_pkg::fp_word_t  a_i,
    input  wire fp_pkg::fp_word_t  b_i,
    input  wire fp_pkg::fp_class_t class_a_i,
    input  wire fp_pkg::fp_class_t class_b_i,
    input  wire logic              is_nan_a_i,
    input  wire logic              is_nan_b_i,
    input  wire logic              is_snan_a_i,
    input  wire logic              is_snan_b_i,
    output fp_pkg::fp_word_t       result_o,
    output fp_pkg::fp_flags_t      flags_o
);

    import fp_pkg::*;

    logic both_zero;
    logic any_nan;
    logic any_snan;
    logic a_lt_b;
    logic a_eq_b;
    logic min_sel_a;

    assign both_zero = (class_a_i[3] | class_a_i[4]) & (class_b_i[3] | class_b_i[4]);
    assign any_nan   = is_nan_a_i | is_nan_b_i;
    assign any_snan  = is_snan_a_i | is_snan_b_i;

    always_comb begin
        if (a_i[31] != b_i[31]) begin
            a_lt_b = a_i[31] & ~both_zero;
        end else if (a_i[31]) begin
            a_lt_b = a_i[30:0] > b_i[30:0]; // Both negative.
        end else begin
            a_lt_b = a_i[30:0] < b_i[30:0];
        end
    end

    assign a_eq_b    = (a_i == b_i) | both_zero;
    assign min_sel_a = a_lt_b | (both_zero & a_i[31]); // -0 below +0.

    always_comb begin
        result_o = '0;
        flags_o  = '0;
        case (op_i)
            FEQ: begin
                result_o[0] = ~any_nan & a_eq_b;
                flags_o     = any_snan ? FLAG_NV : '0;
            end
            FLT: begin
                result_o[0] = ~any_nan & a_lt_b;
                flags_o     = any_nan ? FLAG_NV : '0;
            end
            FLE: begin
                result_o[0] = ~any_nan & (a_lt_b | a_eq_b);
                flags_o     = any_nan ? FLAG_NV : '0;
            end
            FMIN, FMAX: begin
                if (is_nan_a_i & is_nan_b_i) begin
                    result_o = `FP_CANON_NAN;
                end else if (is_nan_a_i) begin
                    result_o = b_i;
                end else if (is_nan_b_i) begin
                    result_o = a_i;
                end else if (op_i == FMIN) begin
                    result_o = min_sel_a ? a_i : b_i;
                end else begin
                    result_o = min_sel_a ? b_i : a_i;
                end
                flags_o = any_snan ? FLAG_NV : '0;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- fp_hub/fp_ext.sv
// ~~~~~~~~~~~~~~~~~~~~
// Operand unpack and ten-way class.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module fp_ext (
    input  wire fp_pkg::fp_word_t data_i,
    output fp_pkg::fp_class_t     class_o,
    output logic                  is_nan_o,
    output logic                  is_snan_o
);

    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
    logic        exp_ones;
    logic        exp_zero;
    logic        man_zero;

    assign sign     = data_i[31];
    assign exp      = data_i[30:23];
    assign man      = data_i[22:0];
    assign exp_ones = &exp;
    assign exp_zero = ~|exp;
    assign man_zero = ~|man;

    assign is_nan_o  = exp_ones & ~man_zero;
    assign is_snan_o = is_nan_o & ~man[22]; // Quiet bit clear.

    assign class_o[0] = sign & exp_ones & man_zero;
    assign class_o[1] = sign & ~exp_zero & ~exp_ones;
    assign class_o[2] = sign & exp_zero & ~man_zero;
    assign class_o[3] = sign & exp_zero & man_zero;
    assign class_o[4] = ~sign & exp_zero & man_zero;
    assign class_o[5] = ~sign & exp_zero & ~man_zero;
    assign class_o[6] = ~sign & ~exp_zero & ~exp_ones;
    assign class_o[7] = ~sign & exp_ones & man_zero;
    assign class_o[8] = is_snan_o;
    assign class_o[9] = is_nan_o & man[22];

endmodule

`default_nettype wire

//--- common/fp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Operand, flag and class types, flag masks,
// operation and FSM state enums.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fp_defines.svh"

package fp_pkg;

    typedef logic [`FP_WIDTH-1:0] fp_word_t;
    typedef logic [4:0]           fp_flags_t; // NV DZ OF UF NX.
    typedef logic [9:0]           fp_class_t; // One-hot, bit 0 is -inf.

    localparam fp_flags_t FLAG_NV = 5'b1_0000;
    localparam fp_flags_t FLAG_NX = 5'b0_0001;

    typedef enum logic [3:0] {
        FEQ,
        FLT,
        FLE,
        FMIN,
        FMAX,
        FSGNJ,
        FSGNJN,
        FSGNJX,
        FCLASS,
        FCVT_W
    } fp_op_e;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_BUSY,
        PORT_ACK,
        PORT_RELEASE
    } port_state_e;

    typedef enum logic [1:0] {
        CVT_IDLE,
        CVT_SHIFT,
        CVT_DONE
    } cvt_state_e;

endpackage

`default_nettype wire

//--- common/fp_defines.svh
// ~~~~~~~~~~~~~~~~~~~~
// Width, bias, NaN and saturation macros.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// Single precision word.
`define FP_WIDTH 32

`define FP_EXP_BIAS 127

// Quiet NaN returned by min/max when both inputs are NaN.
`define FP_CANON_NAN 32'h7fc00000

// Float to int32 saturation values.
`define FP_INT_MAX 32'h7fffffff
`define FP_INT_MIN 32'h80000000

`endif
